// ==== Bender.yml ====
package:
  name: gpif_rd

export_include_dirs:
  - .

sources:
  - gpif_pkg.sv
  - gpif_line_fifo.sv
  - gpif_rd_regs.sv
  - gpif_rd.sv
  - gpif_rd_top.sv
  - target: test
    files:
      - tb_gpif_rd.sv

// ==== gpif_defines.svh ====
`ifndef GPIF_DEFINES_SVH
`define GPIF_DEFINES_SVH

// A system-side line holds 16 data bits, SOP in bit 16 and EOP in bit 17.
`define GPIF_LINE_W 18

// FIFO sizes, in lines.
`define GPIF_DATA_DEPTH_LOG2 10
`define GPIF_RESP_DEPTH_LOG2 5

// Burst counter and burst limits share this width.
`define GPIF_BURST_W 9

// Register values after reset.
`define GPIF_DATA_BURST_RST 9'd256
`define GPIF_RESP_BURST_RST 9'd16

// The threshold is compared with the response occupancy, which is 6 bits wide.
`define GPIF_RESP_LEVEL_RST 6'd16

`endif

// ==== gpif_line_fifo.sv ====
`timescale 1ns/1ps
`include "gpif_defines.svh"

module gpif_line_fifo #(
   parameter int DEPTH_LOG2 = 5
) (
   input  logic                      gpif_clk,
   input  logic                      gpif_rst,
   input  logic                      flush_i,
   input  logic [`GPIF_LINE_W-1:0]   wr_data_i,
   input  logic                      wr_en_i,
   output logic                      full_o,
   output logic [`GPIF_LINE_W-1:0]   rd_data_o,
   input  logic                      rd_en_i,
   output logic                      empty_o,
   output logic [DEPTH_LOG2:0]       level_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [`GPIF_LINE_W-1:0] mem [DEPTH];
   logic [DEPTH_LOG2-1:0]   wr_ptr;
   logic [DEPTH_LOG2-1:0]   rd_ptr;
   logic [DEPTH_LOG2:0]     count;

   // Storage only. The pointers decide what is valid.
   always_ff @(posedge gpif_clk) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // ********************
   // Pointers and occupancy
   // ********************
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst || flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither.
         endcase
      end
   end

   assign rd_data_o = mem[rd_ptr];   // Head line is always visible.
   assign full_o    = (count == DEPTH[DEPTH_LOG2:0]);
   assign empty_o   = (count == '0);
   assign level_o   = count;

endmodule

// ==== gpif_pkg.sv ====
package gpif_pkg;

   // Configuration register map.
   typedef enum logic [1:0] {
      REG_DATA_BURST = 2'd0,
      REG_RESP_BURST = 2'd1,
      REG_RESP_LEVEL = 2'd2,
      REG_CTRL       = 2'd3   // Bit 0 flushes both streams.
   } gpif_reg_e;

   // Endpoint select driven by the USB controller.
   typedef enum logic {
      EP_DATA = 1'b0,
      EP_RESP = 1'b1
   } gpif_ep_e;

endpackage

// ==== gpif_rd.sv ====
`timescale 1ns/1ps
`include "gpif_defines.svh"

module gpif_rd (
   input  logic                       gpif_clk,
   input  logic                       gpif_rst,
   input  logic                       gpif_rd_i,
   input  gpif_pkg::gpif_ep_e         gpif_ep_i,
   output logic [15:0]                gpif_data_o,
   output logic                       gpif_empty_d_o,
   output logic                       gpif_empty_c_o,
   input  logic [`GPIF_LINE_W-1:0]    data_i,
   input  logic                       data_src_rdy_i,
   output logic                       data_dst_rdy_o,
   input  logic [`GPIF_LINE_W-1:0]    resp_i,
   input  logic                       resp_src_rdy_i,
   output logic                       resp_dst_rdy_o,
   input  logic [`GPIF_BURST_W-1:0]   data_burst_i,
   input  logic [`GPIF_BURST_W-1:0]   resp_burst_i,
   input  logic [5:0]                 resp_level_i,
   input  logic                       flush_i
);

   logic [`GPIF_BURST_W-1:0]        burst_cnt;
   logic [`GPIF_LINE_W-1:0]         data_head;
   logic [`GPIF_LINE_W-1:0]         resp_head;
   logic                            data_full, data_empty;
   logic                            resp_full, resp_empty;
   logic [`GPIF_RESP_DEPTH_LOG2:0]  resp_level;
   logic [`GPIF_DATA_DEPTH_LOG2:0]  pkt_cnt;
   logic                            data_wr, resp_wr;
   logic                            data_rd, resp_rd;
   logic                            produce_eop, consume_sop;

   // ********************
   // Burst counter
   // ********************
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst || !gpif_rd_i) begin
         burst_cnt <= '0;
      end else if (burst_cnt != '1) begin
         burst_cnt <= burst_cnt + 1'b1;   // Holds at 511.
      end
   end

   assign data_wr = data_src_rdy_i && !data_full;
   assign resp_wr = resp_src_rdy_i && !resp_full;
   assign data_dst_rdy_o = !data_full;
   assign resp_dst_rdy_o = !resp_full;

   assign data_rd = gpif_rd_i && (gpif_ep_i == gpif_pkg::EP_DATA)
                    && (burst_cnt < data_burst_i) && !data_empty;
   assign resp_rd = gpif_rd_i && (gpif_ep_i == gpif_pkg::EP_RESP)
                    && (burst_cnt < resp_burst_i) && !resp_empty;

   gpif_line_fifo #(.DEPTH_LOG2(`GPIF_DATA_DEPTH_LOG2)) u_data_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .flush_i   (flush_i),
      .wr_data_i (data_i),
      .wr_en_i   (data_wr),
      .full_o    (data_full),
      .rd_data_o (data_head),
      .rd_en_i   (data_rd),
      .empty_o   (data_empty),
      .level_o   ()
   );

   gpif_line_fifo #(.DEPTH_LOG2(`GPIF_RESP_DEPTH_LOG2)) u_resp_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .flush_i   (flush_i),
      .wr_data_i (resp_i),
      .wr_en_i   (resp_wr),
      .full_o    (resp_full),
      .rd_data_o (resp_head),
      .rd_en_i   (resp_rd),
      .empty_o   (resp_empty),
      .level_o   (resp_level)
   );

   // ********************
   // Packet count and flags
   // ********************
   assign produce_eop = data_wr && data_i[17];
   assign consume_sop = data_rd && data_head[16];

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst || flush_i) begin
         pkt_cnt <= '0;
      end else if (produce_eop && !consume_sop) begin
         pkt_cnt <= pkt_cnt + 1'b1;
      end else if (consume_sop && !produce_eop) begin
         pkt_cnt <= pkt_cnt - 1'b1;
      end
   end

   // Both flags trail their source by one edge.
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         gpif_empty_d_o <= 1'b1;
         gpif_empty_c_o <= 1'b1;
      end else begin
         gpif_empty_d_o <= (pkt_cnt == '0);
         gpif_empty_c_o <= (resp_level < resp_level_i);
      end
   end

   assign gpif_data_o = (gpif_ep_i == gpif_pkg::EP_RESP) ? resp_head[15:0] : data_head[15:0];

endmodule

// ==== gpif_rd_regs.sv ====
`timescale 1ns/1ps
`include "gpif_defines.svh"

module gpif_rd_regs (
   input  logic                       gpif_clk,
   input  logic                       gpif_rst,
   input  logic                       cfg_wr_i,
   input  gpif_pkg::gpif_reg_e        cfg_addr_i,
   input  logic [15:0]                cfg_wdata_i,
   output logic [15:0]                cfg_rdata_o,
   output logic [`GPIF_BURST_W-1:0]   data_burst_o,
   output logic [`GPIF_BURST_W-1:0]   resp_burst_o,
   output logic [5:0]                 resp_level_o,
   output logic                       flush_o
);

   logic [`GPIF_BURST_W-1:0] data_burst_q;
   logic [`GPIF_BURST_W-1:0] resp_burst_q;
   logic [5:0]               resp_level_q;
   logic                     flush_q;

   // ********************
   // Register writes
   // ********************
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         data_burst_q <= `GPIF_DATA_BURST_RST;
         resp_burst_q <= `GPIF_RESP_BURST_RST;
         resp_level_q <= `GPIF_RESP_LEVEL_RST;
         flush_q      <= 1'b0;
      end else begin
         // Flush is a single cycle pulse following the control write.
         flush_q <= cfg_wr_i && (cfg_addr_i == gpif_pkg::REG_CTRL) && cfg_wdata_i[0];
         if (cfg_wr_i) begin
            case (cfg_addr_i)
               gpif_pkg::REG_DATA_BURST: data_burst_q <= cfg_wdata_i[`GPIF_BURST_W-1:0];
               gpif_pkg::REG_RESP_BURST: resp_burst_q <= cfg_wdata_i[`GPIF_BURST_W-1:0];
               gpif_pkg::REG_RESP_LEVEL: resp_level_q <= cfg_wdata_i[5:0];
               default: ;   // Control has no storage.
            endcase
         end
      end
   end

   // Readback
   always_comb begin
      case (cfg_addr_i)
         gpif_pkg::REG_DATA_BURST: cfg_rdata_o = {{(16-`GPIF_BURST_W){1'b0}}, data_burst_q};
         gpif_pkg::REG_RESP_BURST: cfg_rdata_o = {{(16-`GPIF_BURST_W){1'b0}}, resp_burst_q};
         gpif_pkg::REG_RESP_LEVEL: cfg_rdata_o = {10'd0, resp_level_q};
         default:                  cfg_rdata_o = 16'd0;   // Flush bit reads as 0.
      endcase
   end

   assign data_burst_o = data_burst_q;
   assign resp_burst_o = resp_burst_q;
   assign resp_level_o = resp_level_q;
   assign flush_o      = flush_q;

endmodule

// ==== gpif_rd_top.sv ====
`timescale 1ns/1ps
`include "gpif_defines.svh"

module gpif_rd_top (
   input  logic                      gpif_clk,
   input  logic                      gpif_rst,
   input  logic                      gpif_rd_i,
   input  gpif_pkg::gpif_ep_e        gpif_ep_i,
   output logic [15:0]               gpif_data_o,
   output logic                      gpif_empty_d_o,
   output logic                      gpif_empty_c_o,
   input  logic [`GPIF_LINE_W-1:0]   data_i,
   input  logic                      data_src_rdy_i,
   output logic                      data_dst_rdy_o,
   input  logic [`GPIF_LINE_W-1:0]   resp_i,
   input  logic                      resp_src_rdy_i,
   output logic                      resp_dst_rdy_o,
   input  logic                      cfg_wr_i,
   input  gpif_pkg::gpif_reg_e       cfg_addr_i,
   input  logic [15:0]               cfg_wdata_i,
   output logic [15:0]               cfg_rdata_o
);

   logic [`GPIF_BURST_W-1:0]        data_burst;
   logic [`GPIF_BURST_W-1:0]        resp_burst;
   logic [`GPIF_RESP_DEPTH_LOG2:0]  resp_level;
   logic                            flush;

   gpif_rd_regs u_regs (
      .gpif_clk (gpif_clk), .gpif_rst (gpif_rst),
      .cfg_wr_i (cfg_wr_i), .cfg_addr_i (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i), .cfg_rdata_o (cfg_rdata_o),
      .data_burst_o (data_burst), .resp_burst_o (resp_burst),
      .resp_level_o (resp_level), .flush_o (flush)
   );

   gpif_rd u_rd (
      .gpif_clk (gpif_clk), .gpif_rst (gpif_rst),
      .gpif_rd_i (gpif_rd_i), .gpif_ep_i (gpif_ep_i), .gpif_data_o (gpif_data_o),
      .gpif_empty_d_o (gpif_empty_d_o), .gpif_empty_c_o (gpif_empty_c_o),
      .data_i (data_i), .data_src_rdy_i (data_src_rdy_i), .data_dst_rdy_o (data_dst_rdy_o),
      .resp_i (resp_i), .resp_src_rdy_i (resp_src_rdy_i), .resp_dst_rdy_o (resp_dst_rdy_o),
      .data_burst_i (data_burst), .resp_burst_i (resp_burst),
      .resp_level_i (resp_level), .flush_i (flush)
   );

endmodule

// ==== tb.f ====
+incdir+.
gpif_pkg.sv
gpif_line_fifo.sv
gpif_rd_regs.sv
gpif_rd.sv
gpif_rd_top.sv
tb_gpif_rd.sv

// ==== tb_gpif_rd.sv ====
`timescale 1ns/1ps
`include "gpif_defines.svh"

module tb_gpif_rd;

   localparam int DATA_DEPTH   = 1 << `GPIF_DATA_DEPTH_LOG2;
   localparam int RESP_DEPTH   = 1 << `GPIF_RESP_DEPTH_LOG2;
   localparam int PHASE_CYCLES = 20 + 3000 + 800 + 600 + 200 + 1600;
   localparam int MAX_CYCLES   = 4 * PHASE_CYCLES;

   logic                      gpif_clk;
   logic                      gpif_rst;
   logic                      gpif_rd_i;
   gpif_pkg::gpif_ep_e        gpif_ep_i;
   logic [15:0]               gpif_data_o;
   logic                      gpif_empty_d_o;
   logic                      gpif_empty_c_o;
   logic [`GPIF_LINE_W-1:0]   data_i;
   logic                      data_src_rdy_i;
   logic                      data_dst_rdy_o;
   logic [`GPIF_LINE_W-1:0]   resp_i;
   logic                      resp_src_rdy_i;
   logic                      resp_dst_rdy_o;
   logic                      cfg_wr_i;
   gpif_pkg::gpif_reg_e       cfg_addr_i;
   logic [15:0]               cfg_wdata_i;
   logic [15:0]               cfg_rdata_o;

   // Reference model state as it stands before the next edge.
   logic [`GPIF_LINE_W-1:0] data_q[$];
   logic [`GPIF_LINE_W-1:0] resp_q[$];
   int    m_pkt;
   int    m_burst;
   int    m_data_burst;
   int    m_resp_burst;
   int    m_level;
   bit    m_flush;
   bit    exp_empty_d;
   bit    exp_empty_c;

   // Stimulus state.
   bit          data_en;
   bit          resp_en;
   bit          data_taken;
   bit          resp_taken;
   int          rd_mode;     // 0 idle, 1 random bursts, 2 long bursts.
   int          pkt_len;
   int          pkt_left;
   int          errors;
   int          cycles;
   string       test_name;
   logic [31:0] rng_state = 32'h7bd4_0202;

   gpif_rd_top dut (.*);

   initial begin
      gpif_clk = 1'b0;
      forever #4 gpif_clk = ~gpif_clk;
   end

   always @(posedge gpif_clk) cycles <= cycles + 1;

   initial begin
      wait (cycles >= MAX_CYCLES);
      $display("ERROR: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d", errors);
      $display("TESTS FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   // Packets of 1 to 40 lines carry SOP on the first line and EOP on the last.
   function automatic logic [`GPIF_LINE_W-1:0] next_data_line();
      logic [31:0] r;
      r = next_rand();
      if (pkt_left == 0) begin
         pkt_len  = int'(r[31:16] % 40) + 1;
         pkt_left = pkt_len;
      end
      next_data_line = {pkt_left == 1, pkt_left == pkt_len, r[15:0]};
      pkt_left--;
   endfunction

   function automatic logic [15:0] reg_readback(gpif_pkg::gpif_reg_e addr);
      case (addr)
         gpif_pkg::REG_DATA_BURST: return 16'(m_data_burst);
         gpif_pkg::REG_RESP_BURST: return 16'(m_resp_burst);
         gpif_pkg::REG_RESP_LEVEL: return 16'(m_level);
         default:                  return 16'd0;
      endcase
   endfunction

   task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
      assert (act === exp) else begin
         errors++;
         $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      end
   endtask

   // ********************
   // Per-cycle checks and model update
   // ********************
   task automatic check_outputs();
      check_value("cfg_rdata_o", reg_readback(cfg_addr_i), cfg_rdata_o);
      check_value("data_dst_rdy_o", data_q.size() < DATA_DEPTH, data_dst_rdy_o);
      check_value("resp_dst_rdy_o", resp_q.size() < RESP_DEPTH, resp_dst_rdy_o);
      check_value("gpif_empty_d_o", exp_empty_d, gpif_empty_d_o);
      check_value("gpif_empty_c_o", exp_empty_c, gpif_empty_c_o);
      if (gpif_rd_i && gpif_ep_i == gpif_pkg::EP_DATA && data_q.size() != 0) begin
         check_value("data gpif_data_o", data_q[0][15:0], gpif_data_o);
      end
      if (gpif_rd_i && gpif_ep_i == gpif_pkg::EP_RESP && resp_q.size() != 0) begin
         check_value("resp gpif_data_o", resp_q[0][15:0], gpif_data_o);
      end
   endtask

   task automatic update_model();
      bit d_acc;
      bit r_acc;
      bit d_rd;
      bit r_rd;
      bit sop;
      bit eop;
      d_acc = data_src_rdy_i && data_q.size() < DATA_DEPTH;
      r_acc = resp_src_rdy_i && resp_q.size() < RESP_DEPTH;
      d_rd  = gpif_rd_i && gpif_ep_i == gpif_pkg::EP_DATA && m_burst < m_data_burst
              && data_q.size() != 0;
      r_rd  = gpif_rd_i && gpif_ep_i == gpif_pkg::EP_RESP && m_burst < m_resp_burst
              && resp_q.size() != 0;
      sop = d_rd && data_q[0][16];
      eop = d_acc && data_i[17];
      exp_empty_d = (m_pkt == 0);
      exp_empty_c = (resp_q.size() < m_level);
      if (m_flush) begin
         data_q.delete();   // Lines offered in the flush cycle are dropped too.
         resp_q.delete();
         m_pkt = 0;
      end else begin
         m_pkt = m_pkt + int'(eop) - int'(sop);
         if (d_rd) void'(data_q.pop_front());
         if (r_rd) void'(resp_q.pop_front());
         if (d_acc) data_q.push_back(data_i);
         if (r_acc) resp_q.push_back(resp_i);
      end
      m_burst = !gpif_rd_i ? 0 : (m_burst == 511 ? 511 : m_burst + 1);
      m_flush = cfg_wr_i && cfg_addr_i == gpif_pkg::REG_CTRL && cfg_wdata_i[0];
      if (cfg_wr_i && cfg_addr_i == gpif_pkg::REG_DATA_BURST) m_data_burst = cfg_wdata_i[8:0];
      if (cfg_wr_i && cfg_addr_i == gpif_pkg::REG_RESP_BURST) m_resp_burst = cfg_wdata_i[8:0];
      if (cfg_wr_i && cfg_addr_i == gpif_pkg::REG_RESP_LEVEL) m_level = cfg_wdata_i[5:0];
      data_taken = d_acc;
      resp_taken = r_acc;
   endtask

   // Sources hold a line until it is accepted.
   task automatic drive_inputs();
      logic [31:0] r;
      logic [31:0] line;
      r    = next_rand();
      line = next_rand();
      if (data_taken) data_i = next_data_line();
      if (resp_taken) resp_i = line[17:0];
      data_src_rdy_i = data_en && (r[1:0] != 2'b00);
      resp_src_rdy_i = resp_en && (r[3:2] != 2'b00);
      case (rd_mode)
         0:       gpif_rd_i = 1'b0;
         1:       gpif_rd_i = gpif_rd_i ? (r[7:4] != 4'h0) : (r[9:8] == 2'b00);
         default: gpif_rd_i = (cycles % 24) < 21;
      endcase
   endtask

   task automatic step();
      #3;
      check_outputs();
      update_model();
      @(posedge gpif_clk);
      #1;
      drive_inputs();
   endtask

   task automatic write_reg(gpif_pkg::gpif_reg_e addr, logic [15:0] value);
      cfg_wr_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = value;
      step();
      cfg_wr_i = 1'b0;
   endtask

   // ********************
   // Test sequence
   // ********************
   initial begin
      logic [31:0] r;
      gpif_rst       = 1'b1;
      gpif_rd_i      = 1'b0;
      gpif_ep_i      = gpif_pkg::EP_DATA;
      data_i         = '0;
      data_src_rdy_i = 1'b0;
      resp_i         = '0;
      resp_src_rdy_i = 1'b0;
      cfg_wr_i       = 1'b0;
      cfg_addr_i     = gpif_pkg::REG_DATA_BURST;
      cfg_wdata_i    = '0;
      m_data_burst   = `GPIF_DATA_BURST_RST;
      m_resp_burst   = `GPIF_RESP_BURST_RST;
      m_level        = `GPIF_RESP_LEVEL_RST;
      exp_empty_d    = 1'b1;
      exp_empty_c    = 1'b1;
      repeat (2) @(posedge gpif_clk);
      #1;
      gpif_rst = 1'b0;
      data_i   = next_data_line();
      r        = next_rand();
      resp_i   = r[17:0];

      test_name = "regs";
      for (int a = 0; a < 4; a++) begin
         cfg_addr_i = gpif_pkg::gpif_reg_e'(a);
         step();   // Reset values.
      end
      for (int a = 0; a < 4; a++) begin
         write_reg(gpif_pkg::gpif_reg_e'(a), next_rand());
         step();
      end

      test_name = "data_order";
      write_reg(gpif_pkg::REG_DATA_BURST, 16'd256);
      write_reg(gpif_pkg::REG_RESP_BURST, 16'd16);
      data_en = 1'b1;
      rd_mode = 1;
      repeat (3000) step();

      test_name = "burst_limit";
      write_reg(gpif_pkg::REG_DATA_BURST, 16'(next_rand() % 8 + 1));
      rd_mode = 2;
      repeat (400) step();
      data_en = 1'b0;
      write_reg(gpif_pkg::REG_RESP_BURST, 16'(next_rand() % 8 + 1));
      gpif_ep_i = gpif_pkg::EP_RESP;
      resp_en   = 1'b1;
      repeat (400) step();

      test_name = "flags";
      write_reg(gpif_pkg::REG_RESP_BURST, 16'd16);
      rd_mode = 1;
      for (int i = 0; i < 12; i++) begin
         write_reg(gpif_pkg::REG_RESP_LEVEL, 16'(next_rand() % 40));
         repeat (49) step();
      end

      test_name = "back_pressure";
      rd_mode = 0;
      while (resp_q.size() < RESP_DEPTH) step();
      repeat (8) step();
      check_value("resp_dst_rdy_o when full", 0, resp_dst_rdy_o);
      resp_en = 1'b0;
      rd_mode = 1;
      while (resp_q.size() != 0) step();   // Every drained line is compared.

      test_name = "flush";
      rd_mode = 0;
      data_en = 1'b1;
      resp_en = 1'b1;
      while (data_q.size() < DATA_DEPTH || resp_q.size() < RESP_DEPTH) step();
      data_en = 1'b0;
      resp_en = 1'b0;
      write_reg(gpif_pkg::REG_CTRL, 16'h0001);
      repeat (2) step();
      check_value("gpif_empty_d_o after flush", 1, gpif_empty_d_o);
      check_value("data_dst_rdy_o after flush", 1, data_dst_rdy_o);
      check_value("resp_dst_rdy_o after flush", 1, resp_dst_rdy_o);
      data_en   = 1'b1;
      resp_en   = 1'b1;
      rd_mode   = 1;
      gpif_ep_i = gpif_pkg::EP_DATA;
      repeat (100) step();
      gpif_ep_i = gpif_pkg::EP_RESP;
      repeat (100) step();

      $display("Errors: %0d in %0d cycles", errors, cycles);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
